// File: common/core_event_if.sv
`default_nettype none

// One cycle of core events.
// Each strobe marks one event in the cycle where it is high.
interface core_event_if
  import core_obs_pkg::*;
();

  // Executed instruction.
  word_t        pc;
  word_t        instr;
  logic         ivalid;

  // Register write-back.
  reg_addr_t    rd_waddr;
  word_t        rd_wdata;
  logic         rd_write;

  // Data memory access.
  // Only a write with mvalid high is traced.
  word_t        maddr;
  word_t        mdata;
  byte_strobe_t mstrb;
  logic         mwrite;
  logic         mvalid;

  // Driven from the top-level ports.
  modport source (
    output pc, instr, ivalid,
    output rd_waddr, rd_wdata, rd_write,
    output maddr, mdata, mstrb, mwrite, mvalid
  );

  // Sampled by the capture stage.
  modport sink (
    input pc, instr, ivalid,
    input rd_waddr, rd_wdata, rd_write,
    input maddr, mdata, mstrb, mwrite, mvalid
  );

endinterface

`default_nettype wire

// File: common/core_obs_pkg.sv
`default_nettype none

// Types of the signals observed on the core side.
package core_obs_pkg;

  // ==================================================
  // Core observation types
  // ==================================================

  // Register file address.
  // Six bits, one more than the 32 architectural registers need.
  typedef logic [5:0] reg_addr_t;

  // Data, address and instruction word.
  typedef logic [31:0] word_t;

  // Byte-lane write mask of a data store.
  // Bit n enables byte n of the word.
  typedef logic [3:0] byte_strobe_t;

endpackage

`default_nettype wire

// File: common/trace_defs.svh
`ifndef TRACE_DEFS_SVH
`define TRACE_DEFS_SVH

// ==================================================
// Trace buffer sizing
// ==================================================

// Record slots in the trace buffer.
// Must stay a power of two so the pointers wrap on their own.
`define TRACE_DEPTH 8

// Read and write pointer width, log2 of the depth.
`define TRACE_PTR_W 3

// Width of the saturating dropped-record counter.
`define TRACE_DROP_W 16

`endif

// File: common/trace_rec_pkg.sv
`default_nettype none

// Layout of one trace record.
package trace_rec_pkg;
  import core_obs_pkg::*;

  // ==================================================
  // Record kinds
  // ==================================================

  // Kind field, selects the payload view.
  typedef enum logic [1:0] {
    REC_EXEC = 2'd0,
    REC_REG  = 2'd1,
    REC_MEM  = 2'd2
  } rec_kind_t;

  // ==================================================
  // Payload views, all 68 bits
  // ==================================================

  // Executed instruction, top bits unused.
  typedef struct packed {
    logic [3:0] pad;
    word_t      pc;
    word_t      instr;
  } exec_view_t;

  // Register write-back.
  typedef struct packed {
    logic [29:0] pad;
    reg_addr_t   waddr;
    word_t       wdata;
  } reg_view_t;

  // Data memory store.
  typedef struct packed {
    byte_strobe_t strb;
    word_t        addr;
    word_t        data;
  } mem_view_t;

  // One payload word, read through the view that kind names.
  typedef union packed {
    exec_view_t exec;
    reg_view_t  regwr;
    mem_view_t  memwr;
  } rec_payload_u;

  // Buffer entry, 70 bits.
  typedef struct packed {
    rec_kind_t    kind;
    rec_payload_u payload;
  } trace_rec_t;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the trace unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module trace_unit_tb -o trace_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/trace_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "PASS: all tests" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// File: src/trace_unit.sv
`default_nettype none

`include "trace_defs.svh"

// Instruction trace unit top.
// Core events in, ordered trace records out.
module trace_unit
  import core_obs_pkg::*, trace_rec_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  // Executed instruction.
  input  word_t                     pc,
  input  word_t                     instr,
  input  logic                      ivalid,
  // Register write-back.
  input  reg_addr_t                 rd_waddr,
  input  word_t                     rd_wdata,
  input  logic                      rd_write,
  // Data memory.
  input  word_t                     maddr,
  input  word_t                     mdata,
  input  byte_strobe_t              mstrb,
  input  logic                      mwrite,
  input  logic                      mvalid,
  // Record read port.
  input  logic                      read_ack,
  output logic                      read_valid,
  output trace_rec_t                read_data,
  output logic [`TRACE_DROP_W-1:0]  drop_count
);

  logic [2:0]       wr_valid;
  trace_rec_t [2:0] wr_rec;

  // ==================================================
  // Core event bundle
  // ==================================================

  core_event_if ev ();

  // Source side of the bundle.
  assign ev.pc       = pc;
  assign ev.instr    = instr;
  assign ev.ivalid   = ivalid;
  assign ev.rd_waddr = rd_waddr;
  assign ev.rd_wdata = rd_wdata;
  assign ev.rd_write = rd_write;
  assign ev.maddr    = maddr;
  assign ev.mdata    = mdata;
  assign ev.mstrb    = mstrb;
  assign ev.mwrite   = mwrite;
  assign ev.mvalid   = mvalid;

  // Event to record lanes, one cycle.
  trace_capture u_capture (
    .clock    (clock),
    .reset    (reset),
    .ev       (ev.sink),
    .wr_valid (wr_valid),
    .wr_rec   (wr_rec)
  );

  // Record store and read port.
  trace_buffer u_buffer (
    .clock      (clock),
    .reset      (reset),
    .wr_valid   (wr_valid),
    .wr_rec     (wr_rec),
    .read_ack   (read_ack),
    .read_valid (read_valid),
    .read_data  (read_data),
    .drop_count (drop_count)
  );

endmodule

`default_nettype wire

// File: tests/trace_unit_tb.sv
`default_nettype none

`include "trace_defs.svh"

// Table-driven testbench for the trace unit, with a queue reference model.
module trace_unit_tb
  import core_obs_pkg::*, trace_rec_pkg::*;
();

  localparam int CMP_W = 70;

  // One table row.
  // ev bits are {ivalid, rd_write, mvalid, mwrite}.
  typedef struct {
    string      name;
    logic [3:0] ev;
    logic       ack;
    logic       rnd;
    logic       fixed;
    word_t      pc;
    word_t      instr;
  } row_t;

  logic                     clock;
  logic                     reset;
  word_t                    pc;
  word_t                    instr;
  logic                     ivalid;
  reg_addr_t                rd_waddr;
  word_t                    rd_wdata;
  logic                     rd_write;
  word_t                    maddr;
  word_t                    mdata;
  byte_strobe_t             mstrb;
  logic                     mwrite;
  logic                     mvalid;
  logic                     read_ack;
  logic                     read_valid;
  trace_rec_t               read_data;
  logic [`TRACE_DROP_W-1:0] drop_count;

  row_t                     rows [$];
  trace_rec_t               model_q [$];
  logic [2:0]               pend_valid;
  trace_rec_t               pend_rec [3];
  logic [`TRACE_DROP_W-1:0] exp_drop;
  integer                   seed = 91782;
  int                       errors = 0;
  int                       cycles = 0;
  int                       limit = 0;

  trace_unit uut (
    .clock      (clock),
    .reset      (reset),
    .pc         (pc),
    .instr      (instr),
    .ivalid     (ivalid),
    .rd_waddr   (rd_waddr),
    .rd_wdata   (rd_wdata),
    .rd_write   (rd_write),
    .maddr      (maddr),
    .mdata      (mdata),
    .mstrb      (mstrb),
    .mwrite     (mwrite),
    .mvalid     (mvalid),
    .read_ack   (read_ack),
    .read_valid (read_valid),
    .read_data  (read_data),
    .drop_count (drop_count)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // Run limit, counted after reset.
  always @(posedge clock) begin
    if (!reset) begin
      cycles = cycles + 1;
      if (cycles > limit) begin
        $display("Timeout: run did not finish within %0d cycles", limit);
        $display("FAIL: see errors above");
        $fatal;
      end
    end
  end

  // ==================================================
  // Helpers
  // ==================================================

  task automatic check(input string name, input logic [CMP_W-1:0] expected,
                       input logic [CMP_W-1:0] actual);
    if (expected !== actual) begin
      errors = errors + 1;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
      $display("FAIL: see errors above");
      $fatal;
    end
  endtask

  task automatic add_row(input string name, input logic [3:0] ev, input logic ack,
                         input logic rnd, input logic fixed, input word_t pc_v,
                         input word_t instr_v);
    row_t r;
    r.name  = name;
    r.ev    = ev;
    r.ack   = ack;
    r.rnd   = rnd;
    r.fixed = fixed;
    r.pc    = pc_v;
    r.instr = instr_v;
    rows.push_back(r);
  endtask

  // Strobes and ack given, payloads random.
  task automatic add_events(input string name, input logic [3:0] ev, input logic ack);
    add_row(name, ev, ack, 1'b0, 1'b0, '0, '0);
  endtask

  // One buffer edge: lanes from capture written, then ack applied.
  task automatic model_edge(input logic ack);
    int free;
    int taken;
    // Room counted before the read.
    free  = `TRACE_DEPTH - model_q.size();
    taken = 0;
    if (ack) model_q.delete(0);
    for (int i = 0; i < 3; i++) begin
      if (pend_valid[i]) begin
        if (taken < free) begin
          model_q.push_back(pend_rec[i]);
          taken = taken + 1;
        end else if (exp_drop != '1) begin
          exp_drop = exp_drop + 1'b1;
        end
      end
    end
  endtask

  // Capture stage, records formed from the driven inputs.
  task automatic model_capture();
    pend_valid = {mvalid && mwrite, rd_write, ivalid};
    pend_rec[0].kind                = REC_EXEC;
    pend_rec[0].payload.exec.pad    = '0;
    pend_rec[0].payload.exec.pc     = pc;
    pend_rec[0].payload.exec.instr  = instr;
    pend_rec[1].kind                = REC_REG;
    pend_rec[1].payload.regwr.pad   = '0;
    pend_rec[1].payload.regwr.waddr = rd_waddr;
    pend_rec[1].payload.regwr.wdata = rd_wdata;
    pend_rec[2].kind                = REC_MEM;
    pend_rec[2].payload.memwr.strb  = mstrb;
    pend_rec[2].payload.memwr.addr  = maddr;
    pend_rec[2].payload.memwr.data  = mdata;
  endtask

  // ==================================================
  // Stimulus table and main loop
  // ==================================================

  initial begin
    row_t        r;
    logic [31:0] rnd;
    logic [3:0]  ev_bits;
    logic        ack_req;
    logic        do_ack;

    // Behaviors 1 to 3.
    add_events("reset_idle", 4'b0000, 1'b0);
    add_row("single_exec", 4'b1000, 1'b0, 1'b0, 1'b1, 32'h0000_1000, 32'h0010_0093);
    add_events("single_exec", 4'b0000, 1'b0);
    add_events("single_exec", 4'b0000, 1'b1);
    add_events("three_lanes", 4'b1111, 1'b0);
    add_events("three_lanes", 4'b0000, 1'b0);
    repeat (3) add_events("three_lanes", 4'b0000, 1'b1);
    add_events("mem_gated", 4'b0010, 1'b0);
    add_events("mem_gated", 4'b0001, 1'b0);
    repeat (3) add_events("mem_gated", 4'b0000, 1'b1);
    // Fill to seven, then three lanes with room for one.
    add_events("fill_drop", 4'b1111, 1'b0);
    add_events("fill_drop", 4'b1111, 1'b0);
    add_events("fill_drop", 4'b1000, 1'b0);
    add_events("fill_drop", 4'b1111, 1'b0);
    repeat (2) add_events("fill_drop", 4'b0000, 1'b0);
    // Full buffer, reads racing writes.
    add_events("full_rw", 4'b1111, 1'b0);
    add_events("full_rw", 4'b0000, 1'b1);
    add_events("full_rw", 4'b1110, 1'b1);
    add_events("full_rw", 4'b0000, 1'b1);
    add_events("full_rw", 4'b1111, 1'b1);
    add_events("full_rw", 4'b0000, 1'b1);
    repeat (10) add_events("drain", 4'b0000, 1'b1);
    // Behavior 6, strobes and ack drawn per row.
    repeat (200) add_row("random_mix", 4'b0000, 1'b0, 1'b1, 1'b0, '0, '0);
    repeat (12) add_events("final_drain", 4'b0000, 1'b1);
    limit = rows.size() + 64;

    reset      = 1'b1;
    pc         = '0;
    instr      = '0;
    ivalid     = 1'b0;
    rd_waddr   = '0;
    rd_wdata   = '0;
    rd_write   = 1'b0;
    maddr      = '0;
    mdata      = '0;
    mstrb      = '0;
    mwrite     = 1'b0;
    mvalid     = 1'b0;
    read_ack   = 1'b0;
    pend_valid = '0;
    exp_drop   = '0;

    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    for (int n = 0; n < rows.size(); n++) begin
      r = rows[n];
      if (r.rnd) begin
        rnd     = $random(seed);
        ev_bits = rnd[3:0];
        ack_req = rnd[4] | rnd[5];
      end else begin
        ev_bits = r.ev;
        ack_req = r.ack;
      end
      // State after the last edge.
      check({r.name, "/read_valid"}, CMP_W'(model_q.size() != 0), CMP_W'(read_valid));
      check({r.name, "/drop_count"}, CMP_W'(exp_drop), CMP_W'(drop_count));
      // Ack only offered on a non-empty buffer.
      do_ack = ack_req && (model_q.size() != 0);
      if (do_ack) begin
        check({r.name, "/read_data"}, CMP_W'(model_q[0]), CMP_W'(read_data));
      end
      // New inputs for the coming edge.
      ivalid   = ev_bits[3];
      rd_write = ev_bits[2];
      mvalid   = ev_bits[1];
      mwrite   = ev_bits[0];
      read_ack = do_ack;
      if (r.fixed) begin
        pc    = r.pc;
        instr = r.instr;
      end else begin
        pc    = $random(seed);
        instr = $random(seed);
      end
      rnd      = $random(seed);
      rd_waddr = {1'b0, rnd[4:0]};
      mstrb    = (rnd[11:8] == 4'h0) ? 4'h1 : rnd[11:8];
      rd_wdata = $random(seed);
      maddr    = $random(seed);
      mdata    = $random(seed);
      model_edge(do_ack);
      model_capture();
      @(negedge clock);
    end

    // State after the final edge.
    check("final_drain/read_valid", CMP_W'(model_q.size() != 0), CMP_W'(read_valid));
    check("final_drain/drop_count", CMP_W'(exp_drop), CMP_W'(drop_count));
    check("final_drain/queue_empty", '0, CMP_W'(model_q.size()));
    if (errors == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal;
    end
  end

endmodule

`default_nettype wire

// File: trace/trace_buffer.sv
`default_nettype none

`include "trace_defs.svh"

// In-order record buffer.
// Up to three writes and one read per cycle; overflow is dropped and counted.
module trace_buffer
  import trace_rec_pkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic [2:0]                wr_valid,
  input  trace_rec_t [2:0]          wr_rec,
  input  logic                      read_ack,
  output logic                      read_valid,
  output trace_rec_t                read_data,
  output logic [`TRACE_DROP_W-1:0]  drop_count
);

  localparam int DEPTH  = `TRACE_DEPTH;
  localparam int PTR_W  = `TRACE_PTR_W;
  localparam int CNT_W  = PTR_W + 1;
  localparam int DROP_W = `TRACE_DROP_W;
  localparam int LANES  = 3;

  // Record storage.
  trace_rec_t            buf_q [DEPTH];

  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count_q;
  logic [CNT_W-1:0]      free_slots;
  logic                  do_read;
  logic [1:0]            n_acc;
  logic [1:0]            n_drop;
  logic [LANES-1:0]      lane_acc;
  logic [PTR_W-1:0]      lane_slot [LANES];
  logic [DROP_W:0]       drop_sum;

  // ==================================================
  // Read side
  // ==================================================

  // Oldest record shown whenever the buffer holds one.
  assign read_valid = (count_q != '0);
  assign read_data  = buf_q[rd_ptr];
  assign do_read    = read_ack && read_valid;

  // ==================================================
  // Write compaction and drop rule
  // ==================================================

  // Room measured before this cycle's read.
  // A slot freed by the read is reused next cycle at the earliest.
  assign free_slots = CNT_W'(DEPTH) - count_q;

  always_comb begin
    n_acc  = '0;
    n_drop = '0;
    for (int i = 0; i < LANES; i++) begin
      lane_acc[i]  = 1'b0;
      // Next free slot after the lanes already taken.
      lane_slot[i] = wr_ptr + PTR_W'(n_acc);
      if (wr_valid[i]) begin
        if (CNT_W'(n_acc) < free_slots) begin
          lane_acc[i] = 1'b1;
          n_acc       = n_acc + 2'd1;
        end else begin
          n_drop = n_drop + 2'd1;
        end
      end
    end
  end

  // Wide sum, the top bit flags saturation.
  assign drop_sum = (DROP_W + 1)'(drop_count) + (DROP_W + 1)'(n_drop);

  // ==================================================
  // State update
  // ==================================================

  // Accepted lanes go to consecutive slots.
  always_ff @(posedge clock) begin
    for (int i = 0; i < LANES; i++) begin
      if (lane_acc[i]) buf_q[lane_slot[i]] <= wr_rec[i];
    end
  end

  // Pointers, occupancy and drop counter.
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count_q    <= '0;
      drop_count <= '0;
    end else begin
      wr_ptr  <= wr_ptr + PTR_W'(n_acc);
      rd_ptr  <= rd_ptr + PTR_W'(do_read);
      count_q <= count_q + CNT_W'(n_acc) - CNT_W'(do_read);
      // Sticks at all ones.
      drop_count <= drop_sum[DROP_W] ? '1 : drop_sum[DROP_W-1:0];
    end
  end

  // Occupancy bound holds across the compaction and the read.
  a_occupancy: assert property (@(posedge clock) disable iff (reset)
    count_q <= CNT_W'(DEPTH))
    else $error("trace_buffer: occupancy above depth");

  // Consumer must not acknowledge an empty buffer.
  a_ack_empty: assert property (@(posedge clock) disable iff (reset)
    read_ack |-> read_valid)
    else $error("trace_buffer: read_ack while empty");

endmodule

`default_nettype wire

// File: trace/trace_capture.sv
`default_nettype none

// Turns one cycle of core events into up to three records.
// One cycle of latency from event to record lane.
module trace_capture
  import trace_rec_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  core_event_if.sink        ev,
  output logic [2:0]        wr_valid,
  output trace_rec_t [2:0]  wr_rec
);

  // Fixed lane order.
  localparam int LANE_EXEC = 0;
  localparam int LANE_REG  = 1;
  localparam int LANE_MEM  = 2;

  // Highest legal architectural register index plus one.
  localparam int NUM_ARCH_REGS = 32;

  logic       mem_hit;
  trace_rec_t exec_rec;
  trace_rec_t reg_rec;
  trace_rec_t mem_rec;

  // Reads and non-valid writes are not traced.
  assign mem_hit = ev.mvalid && ev.mwrite;

  // ==================================================
  // Record formation
  // ==================================================

  always_comb begin
    // Exec lane.
    exec_rec.kind                  = REC_EXEC;
    exec_rec.payload.exec.pad      = '0;
    exec_rec.payload.exec.pc       = ev.pc;
    exec_rec.payload.exec.instr    = ev.instr;
    // Register lane.
    reg_rec.kind                   = REC_REG;
    reg_rec.payload.regwr.pad      = '0;
    reg_rec.payload.regwr.waddr    = ev.rd_waddr;
    reg_rec.payload.regwr.wdata    = ev.rd_wdata;
    // Memory lane.
    mem_rec.kind                   = REC_MEM;
    mem_rec.payload.memwr.strb     = ev.mstrb;
    mem_rec.payload.memwr.addr     = ev.maddr;
    mem_rec.payload.memwr.data     = ev.mdata;
  end

  // ==================================================
  // Lane registers
  // ==================================================

  // Lane valid flags.
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_valid <= '0;
    end else begin
      wr_valid[LANE_EXEC] <= ev.ivalid;
      wr_valid[LANE_REG]  <= ev.rd_write;
      wr_valid[LANE_MEM]  <= mem_hit;
    end
  end

  // Payloads only load on a live event, idle lanes hold.
  always_ff @(posedge clock) begin
    if (ev.ivalid) wr_rec[LANE_EXEC] <= exec_rec;
    if (ev.rd_write) wr_rec[LANE_REG] <= reg_rec;
    if (mem_hit) wr_rec[LANE_MEM] <= mem_rec;
  end

  // A counted store carries a live byte mask.
  a_mem_strb: assert property (@(posedge clock) disable iff (reset)
    mem_hit |-> (ev.mstrb != '0))
    else $error("trace_capture: memory write with empty strobe");

  // A write-back names an architectural register.
  a_reg_addr: assert property (@(posedge clock) disable iff (reset)
    ev.rd_write |-> (ev.rd_waddr < NUM_ARCH_REGS))
    else $error("trace_capture: register write-back above x31");

endmodule

`default_nettype wire

// File: vlog.f
+incdir+common
common/core_obs_pkg.sv
common/trace_rec_pkg.sv
common/core_event_if.sv
trace/trace_capture.sv
trace/trace_buffer.sv
src/trace_unit.sv
tests/trace_unit_tb.sv
